/* src/bf16Pkg.sv */
package bf16Pkg;

    // ------------------------------------------------------------------------
    // bfloat16 format
    // ------------------------------------------------------------------------

    localparam int expWidth = 8;
    localparam int manWidth = 7;

    localparam logic [expWidth-1:0] expBias    = 8'd127;
    // exponent value reserved for overflow results
    localparam logic [expWidth-1:0] expAllOnes = 8'hFF;

    typedef struct packed {
        logic                sign;
        logic [expWidth-1:0] exponent;
        logic [manWidth-1:0] mantissa;
    } bf16Fields;

    // the same word seen either as raw bits or as its fields
    typedef union packed {
        logic [15:0] raw;
        bf16Fields   f;
    } bf16Word;

    // ------------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------------

    localparam logic [4:0] regOpA     = 5'h00;
    localparam logic [4:0] regOpB     = 5'h04;
    localparam logic [4:0] regCtrl    = 5'h08;
    localparam logic [4:0] regResult  = 5'h0C;
    localparam logic [4:0] regStatus  = 5'h10;

    // control word
    localparam int ctrlStartBit = 0;
    localparam int ctrlOpBit    = 1;

    localparam logic opDiv = 1'b0;
    localparam logic opMul = 1'b1;

    // status word, also the bit order of the 4-bit flag vector
    localparam int flagUnderflow = 0;
    localparam int flagOverflow  = 1;
    localparam int flagInexact   = 2;
    localparam int flagDivZero   = 3;
    localparam int statusDone    = 8;

endpackage

/* src/fpOperandIf.sv */
`timescale 1ns/1ps

interface fpOperandIf;
    import bf16Pkg::*;

    // launch side
    logic       launch;
    logic       opCode;
    bf16Word    opA;
    bf16Word    opB;

    // completion side, valid for one cycle after launch
    logic       resultValid;
    bf16Word    result;
    logic [3:0] flags;

    modport regs (
        output launch,
        output opCode,
        output opA,
        output opB,
        input  resultValid,
        input  result,
        input  flags
    );

    modport core (
        input  launch,
        input  opCode,
        input  opA,
        input  opB,
        output resultValid,
        output result,
        output flags
    );

endinterface

/* src/bf16Divider.sv */
`timescale 1ns/1ps

module bf16Divider (
    input  bf16Pkg::bf16Word opA,
    input  bf16Pkg::bf16Word opB,
    output bf16Pkg::bf16Word quotient,
    output logic             underflow,
    output logic             overflow,
    output logic             inexact
);
    import bf16Pkg::*;

    logic [14:0] dividend;
    logic [14:0] divisor;
    logic [7:0]  manQuot;
    logic [7:0]  remainder;
    logic        borrow;
    logic [7:0]  expDiff;
    logic [7:0]  biasedExp;
    logic [3:0]  shift;
    logic [7:0]  normMan;
    logic [7:0]  finalExp;
    logic        sign;

    // ------------------------------------------------------------------------
    // mantissa division
    // ------------------------------------------------------------------------

    // dividend carries seven extra zero bits so the quotient keeps 7 fraction bits
    assign dividend = {1'b1, opA.f.mantissa, {manWidth{1'b0}}};
    assign divisor  = {7'd0, 1'b1, opB.f.mantissa};

    // 1.x / 1.y lies in (0.5, 2), so the integer quotient fits in 8 bits
    assign manQuot   = 8'(dividend / divisor);
    assign remainder = 8'(dividend % divisor);

    // ------------------------------------------------------------------------
    // exponent subtraction
    // ------------------------------------------------------------------------

    assign {borrow, expDiff} = {1'b0, opA.f.exponent} - {1'b0, opB.f.exponent};
    assign biasedExp         = expDiff + expBias;

    // ------------------------------------------------------------------------
    // normalization
    // ------------------------------------------------------------------------

    // leading-one search where the highest set bit wins
    always_comb begin
        shift = 4'd8;
        for (int i = 0; i < 8; i++) begin
            if (manQuot[i]) begin
                shift = 4'(7 - i);
            end
        end
    end

    assign normMan  = manQuot << shift;
    assign finalExp = biasedExp - {4'd0, shift};
    assign sign     = opA.f.sign ^ opB.f.sign;

    // exceptions
    assign overflow  = (finalExp == expAllOnes);
    // a large negative difference wraps and would look like a normal exponent
    assign underflow = (borrow && (expDiff < 8'd130)) || (finalExp == 8'd0);
    assign inexact   = (remainder != 8'd0);

    // truncated result with the hidden one dropped
    assign quotient.raw = {sign, finalExp, overflow ? 7'd0 : normMan[6:0]};

endmodule

/* src/bf16Multiplier.sv */
`timescale 1ns/1ps

module bf16Multiplier (
    input  bf16Pkg::bf16Word opA,
    input  bf16Pkg::bf16Word opB,
    output bf16Pkg::bf16Word product,
    output logic             underflow,
    output logic             overflow,
    output logic             inexact
);
    import bf16Pkg::*;

    logic              zeroOp;
    logic              sign;
    logic [15:0]       manProd;
    logic              prodHigh;
    logic [6:0]        truncMan;
    logic              lostBits;
    logic signed [9:0] expSum;

    // either operand zero apart from its sign
    assign zeroOp = (opA.raw[14:0] == '0) || (opB.raw[14:0] == '0);
    assign sign   = opA.f.sign ^ opB.f.sign;

    // ------------------------------------------------------------------------
    // mantissa product
    // ------------------------------------------------------------------------

    assign manProd  = {1'b1, opA.f.mantissa} * {1'b1, opB.f.mantissa};
    // product lies in [1, 4), bit 15 marks the upper half
    assign prodHigh = manProd[15];
    assign truncMan = prodHigh ? manProd[14:8] : manProd[13:7];
    assign lostBits = prodHigh ? (|manProd[7:0]) : (|manProd[6:0]);

    // ten bits hold the full sum range without wrapping
    assign expSum = {2'b00, opA.f.exponent} + {2'b00, opB.f.exponent}
                  - {2'b00, expBias} + {9'd0, prodHigh};

    // ------------------------------------------------------------------------
    // range checks
    // ------------------------------------------------------------------------

    always_comb begin
        product.raw = {sign, expSum[7:0], truncMan};
        underflow   = 1'b0;
        overflow    = 1'b0;
        inexact     = lostBits;
        if (zeroOp) begin
            product.raw = {sign, 15'd0};
            inexact     = 1'b0;
        end else if (expSum >= 10'sd255) begin
            product.raw = {sign, expAllOnes, 7'd0};
            overflow    = 1'b1;
        end else if (expSum <= 10'sd0) begin
            // flush to signed zero
            product.raw = {sign, 15'd0};
            underflow   = 1'b1;
        end
    end

endmodule

/* src/bf16ArithCore.sv */
`timescale 1ns/1ps

module bf16ArithCore (
    input logic      clk,
    input logic      rstN,
    fpOperandIf.core bus
);
    import bf16Pkg::*;

    bf16Word    divQuot;
    bf16Word    mulProd;
    bf16Word    nextResult;
    logic       divUnderflow;
    logic       divOverflow;
    logic       divInexact;
    logic       mulUnderflow;
    logic       mulOverflow;
    logic       mulInexact;
    logic       divZero;
    logic [3:0] nextFlags;

    bf16Divider u_bf16Divider (
        .opA       (bus.opA),
        .opB       (bus.opB),
        .quotient  (divQuot),
        .underflow (divUnderflow),
        .overflow  (divOverflow),
        .inexact   (divInexact)
    );

    bf16Multiplier u_bf16Multiplier (
        .opA       (bus.opA),
        .opB       (bus.opB),
        .product   (mulProd),
        .underflow (mulUnderflow),
        .overflow  (mulOverflow),
        .inexact   (mulInexact)
    );

    assign divZero = (bus.opB.raw == '0);

    // ------------------------------------------------------------------------
    // result select
    // ------------------------------------------------------------------------

    always_comb begin
        nextResult = divQuot;
        nextFlags  = '0;
        unique case (bus.opCode)
            opDiv: begin
                if (divZero) begin
                    // signed infinity with the divider flags ignored
                    nextResult.raw         = {bus.opA.f.sign ^ bus.opB.f.sign, expAllOnes, 7'd0};
                    nextFlags[flagDivZero] = 1'b1;
                end else begin
                    nextFlags[flagUnderflow] = divUnderflow;
                    nextFlags[flagOverflow]  = divOverflow;
                    nextFlags[flagInexact]   = divInexact;
                end
            end
            opMul: begin
                nextResult               = mulProd;
                nextFlags[flagUnderflow] = mulUnderflow;
                nextFlags[flagOverflow]  = mulOverflow;
                nextFlags[flagInexact]   = mulInexact;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bus.resultValid <= 1'b0;
        end else begin
            bus.resultValid <= bus.launch;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.launch) begin
            bus.result <= nextResult;
            bus.flags  <= nextFlags;
        end
    end

    // one operation in flight, so the valid pulse never stretches
    validOnePulse: assert property (@(posedge clk) disable iff (!rstN)
        bus.resultValid |=> !bus.resultValid);

endmodule

/* src/bf16ApbRegs.sv */
`timescale 1ns/1ps

module bf16ApbRegs (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    fpOperandIf.regs    bus
);
    import bf16Pkg::*;

    logic        access;
    logic        wrAccess;
    logic        mapped;
    logic        wrOpA;
    logic        wrOpB;
    logic        wrCtrl;
    logic        wrStatus;
    bf16Word     resultReg;
    logic [3:0]  stickyFlags;
    logic [3:0]  flagClear;
    logic [3:0]  flagSet;
    logic        done;
    logic [31:0] readData;

    // ------------------------------------------------------------------------
    // access decode
    // ------------------------------------------------------------------------

    // no wait states so every access finishes in its access phase
    assign pready   = 1'b1;
    assign access   = psel && penable;
    assign wrAccess = access && pwrite;

    assign wrOpA    = wrAccess && (paddr == regOpA);
    assign wrOpB    = wrAccess && (paddr == regOpB);
    assign wrCtrl   = wrAccess && (paddr == regCtrl);
    assign wrStatus = wrAccess && (paddr == regStatus);

    // operands, opcode and the launch pulse
    always_ff @(posedge clk) begin
        if (!rstN) begin
            bus.opA    <= '0;
            bus.opB    <= '0;
            bus.opCode <= opDiv;
            bus.launch <= 1'b0;
        end else begin
            bus.launch <= wrCtrl && pwdata[ctrlStartBit];
            if (wrOpA) begin
                bus.opA.raw <= pwdata[15:0];
            end
            if (wrOpB) begin
                bus.opB.raw <= pwdata[15:0];
            end
            if (wrCtrl) begin
                bus.opCode <= pwdata[ctrlOpBit];
            end
        end
    end

    // ------------------------------------------------------------------------
    // result capture and sticky status
    // ------------------------------------------------------------------------

    // write-one-to-clear
    assign flagClear = wrStatus ? pwdata[flagDivZero:flagUnderflow] : '0;
    assign flagSet   = bus.resultValid ? bus.flags : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultReg   <= '0;
            stickyFlags <= '0;
            done        <= 1'b0;
        end else begin
            stickyFlags <= (stickyFlags & ~flagClear) | flagSet;
            if (bus.resultValid) begin
                resultReg <= bus.result;
                done      <= 1'b1;
            end else if (wrCtrl || (wrStatus && pwdata[statusDone])) begin
                done <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------------

    always_comb begin
        readData = '0;
        mapped   = 1'b1;
        case (paddr)
            regOpA:    readData[15:0] = bus.opA.raw;
            regOpB:    readData[15:0] = bus.opB.raw;
            regCtrl:   readData[ctrlOpBit] = bus.opCode;
            regResult: readData[15:0] = resultReg.raw;
            regStatus: begin
                readData[flagDivZero:flagUnderflow] = stickyFlags;
                readData[statusDone]                = done;
            end
            default:   mapped = 1'b0;
        endcase
    end

    assign prdata  = (access && !pwrite) ? readData : '0;
    // the result register is read-only
    assign pslverr = access && (!mapped || (pwrite && (paddr == regResult)));

    // a control write occupies a single access phase
    launchOnePulse: assert property (@(posedge clk) disable iff (!rstN)
        bus.launch |=> !bus.launch);

endmodule

/* src/bf16Coprocessor.sv */
`timescale 1ns/1ps

module bf16Coprocessor (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    // operand and result path between register block and core
    fpOperandIf opBus ();

    bf16ApbRegs u_bf16ApbRegs (
        .clk     (clk),
        .rstN    (rstN),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .bus     (opBus.regs)
    );

    bf16ArithCore u_bf16ArithCore (
        .clk  (clk),
        .rstN (rstN),
        .bus  (opBus.core)
    );

endmodule

/* tb/bf16CoprocessorTb.sv */
`timescale 1ns/1ps

module bf16CoprocessorTb;
    import bf16Pkg::*;

    // about 600 accesses are issued; the limit leaves a margin on top
    localparam int plannedAccesses = 640;
    localparam int cycleLimit      = 40 * plannedAccesses + 200;

    logic        clk;
    logic        rstN;
    logic [4:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          errors;
    int          cycles;
    logic [15:0] lfsrState;

    bf16Coprocessor u_bf16Coprocessor (
        .clk     (clk),
        .rstN    (rstN),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("simulation ran past %0d cycles without finishing", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    // 16-bit Galois LFSR stepped once per bit
    function automatic logic nextBit();
        logic lsb;
        lsb = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic int randBits(int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | nextBit();
        end
        return value;
    endfunction

    // in-range operand with its exponent within 100..154
    function automatic logic [15:0] randOperand();
        logic       s;
        logic [7:0] e;
        logic [6:0] m;
        s = nextBit();
        e = 8'(100 + randBits(6) % 55);
        m = 7'(randBits(7));
        return {s, e, m};
    endfunction

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string msg);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic apbWrite(input logic [4:0] addr, input logic [31:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        checkEq(pready, 1, "pready in write access phase");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbRead(input logic [4:0] addr, output logic [31:0] data,
                           output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        checkEq(pready, 1, "pready in read access phase");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // reference models returning {flags, result}
    // ------------------------------------------------------------------------

    function automatic logic [19:0] refDiv(logic [15:0] a, logic [15:0] b);
        int         num;
        int         den;
        int         q;
        int         r;
        int         shift;
        logic [7:0] diff;
        logic [7:0] e;
        logic [6:0] m;
        logic       s;
        logic [3:0] fl;
        s  = a[15] ^ b[15];
        fl = '0;
        if (b == 16'd0) begin
            fl[flagDivZero] = 1'b1;
            return {fl, s, 8'hFF, 7'd0};
        end
        num   = ({1'b1, a[6:0]}) << 7;
        den   = {1'b1, b[6:0]};
        q     = num / den;
        r     = num % den;
        // quotient of 1.x by 1.y is above 0.5 so at most one shift is needed
        shift = (q >= 128) ? 0 : 1;
        m     = 7'(q << shift);
        diff  = 8'(int'(a[14:7]) - int'(b[14:7]));
        e     = 8'(int'(diff) + 127 - shift);
        fl[flagOverflow]  = (e == 8'hFF);
        fl[flagUnderflow] = ((a[14:7] < b[14:7]) && (diff < 8'd130)) || (e == 8'd0);
        fl[flagInexact]   = (r != 0);
        if (fl[flagOverflow]) begin
            m = 7'd0;
        end
        return {fl, s, e, m};
    endfunction

    function automatic logic [19:0] refMul(logic [15:0] a, logic [15:0] b);
        logic [15:0] p;
        int          e;
        logic [6:0]  m;
        logic        s;
        logic [3:0]  fl;
        s  = a[15] ^ b[15];
        fl = '0;
        if (a[14:0] == 15'd0 || b[14:0] == 15'd0) begin
            return {fl, s, 15'd0};
        end
        p = {1'b1, a[6:0]} * {1'b1, b[6:0]};
        if (p[15]) begin
            m = p[14:8];
            e = int'(a[14:7]) + int'(b[14:7]) - 126;
            fl[flagInexact] = (p[7:0] != 0);
        end else begin
            m = p[13:7];
            e = int'(a[14:7]) + int'(b[14:7]) - 127;
            fl[flagInexact] = (p[6:0] != 0);
        end
        if (e >= 255) begin
            fl[flagOverflow] = 1'b1;
            return {fl, s, 8'hFF, 7'd0};
        end
        if (e <= 0) begin
            fl[flagUnderflow] = 1'b1;
            return {fl, s, 15'd0};
        end
        return {fl, s, 8'(e), m};
    endfunction

    // clears status, runs one operation and checks result and status
    task automatic runOp(input logic op, input logic [15:0] a, input logic [15:0] b);
        logic [19:0] expected;
        logic [31:0] data;
        logic        err;
        string       tag;
        expected = (op == opMul) ? refMul(a, b) : refDiv(a, b);
        tag = $sformatf("%s %h %h", (op == opMul) ? "mul" : "div", a, b);
        apbWrite(regStatus, 32'h10F, err);
        apbWrite(regOpA, {16'd0, a}, err);
        apbWrite(regOpB, {16'd0, b}, err);
        apbWrite(regCtrl, {30'd0, op, 1'b1}, err);
        checkEq(err, 0, {tag, " ctrl pslverr"});
        apbRead(regResult, data, err);
        checkEq(data, {16'd0, expected[15:0]}, {tag, " result"});
        apbRead(regStatus, data, err);
        checkEq(data, 32'h100 | expected[19:16], {tag, " status"});
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------

    task automatic testReset();
        logic [31:0] data;
        logic        err;
        apbRead(regResult, data, err);
        checkEq(data, 0, "result after reset");
        checkEq(err, 0, "pslverr after reset");
        apbRead(regStatus, data, err);
        checkEq(data, 0, "status after reset");
    endtask

    task automatic testDivide();
        checkEq(refDiv(16'h4040, 16'h3FC0), {4'b0000, 16'h4000}, "model 3.0 / 1.5");
        checkEq(refDiv(16'h3F80, 16'h4040) >> 18 & 1, 1, "model 1.0 / 3.0 inexact");
        runOp(opDiv, 16'h4040, 16'h3FC0);
        runOp(opDiv, 16'h3F80, 16'h4040);
        runOp(opDiv, 16'hC0A0, 16'h4000);
        runOp(opDiv, 16'h3F80, 16'h3F80);
        repeat (40) begin
            runOp(opDiv, randOperand(), randOperand());
        end
    endtask

    task automatic testMultiply();
        runOp(opMul, 16'h4040, 16'h4000);
        runOp(opMul, 16'hBFC0, 16'h3FC0);
        runOp(opMul, 16'h0000, 16'h4040);
        runOp(opMul, 16'hC040, 16'h8000);
        repeat (40) begin
            runOp(opMul, randOperand(), randOperand());
        end
    endtask

    task automatic testExceptions();
        checkEq(refDiv(16'h6400, 16'h2400) >> 17 & 1, 1, "model div overflow");
        checkEq(refDiv(16'h0280, 16'h6400) >> 16 & 1, 1, "model div underflow");
        checkEq(refDiv(16'hC000, 16'h0000), {4'b1000, 16'hFF80}, "model div by zero");
        runOp(opDiv, 16'h6400, 16'h2400);
        runOp(opDiv, 16'h0280, 16'h6400);
        runOp(opMul, 16'h7F00, 16'h7F00);
        runOp(opMul, 16'h0080, 16'h0080);
        runOp(opDiv, 16'hC000, 16'h0000);
    endtask

    task automatic testStickyFlags();
        logic [31:0] data;
        logic        err;
        runOp(opDiv, 16'h3F80, 16'h4040);
        // second operation without a clear so the flags pile up
        apbWrite(regOpA, 32'h7F00, err);
        apbWrite(regOpB, 32'h7F00, err);
        apbWrite(regCtrl, 32'h3, err);
        apbRead(regStatus, data, err);
        checkEq(data, 32'h106, "inexact and overflow accumulated");
        apbWrite(regStatus, 32'h4, err);
        apbRead(regStatus, data, err);
        checkEq(data, 32'h102, "inexact cleared alone");
        // control write without start still drops done
        apbWrite(regCtrl, 32'h2, err);
        apbRead(regStatus, data, err);
        checkEq(data, 32'h002, "done cleared by control write");
        apbWrite(regStatus, 32'hF, err);
        apbRead(regStatus, data, err);
        checkEq(data, 0, "all flags cleared");
    endtask

    task automatic testBusErrors();
        logic [31:0] data;
        logic        err;
        // 3.0 times 2.0 leaves 6.0 in the result register
        runOp(opMul, 16'h4040, 16'h4000);
        apbWrite(regOpA, 32'h1234, err);
        apbRead(5'h14, data, err);
        checkEq(err, 1, "unmapped read pslverr");
        apbWrite(5'h18, 32'hFFFF, err);
        checkEq(err, 1, "unmapped write pslverr");
        apbWrite(regResult, 32'hBEEF, err);
        checkEq(err, 1, "result write pslverr");
        apbRead(regResult, data, err);
        checkEq(data, 32'h40C0, "result unchanged");
        checkEq(err, 0, "result read pslverr");
        apbRead(regOpA, data, err);
        checkEq(data, 32'h1234, "operand A unchanged");
    endtask

    initial begin
        errors    = 0;
        cycles    = 0;
        lfsrState = 16'd18757;
        rstN      = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        testReset();
        testDivide();
        testMultiply();
        testExceptions();
        testStickyFlags();
        testBusErrors();
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* bf16Coprocessor.f */
src/bf16Pkg.sv
src/fpOperandIf.sv
src/bf16Divider.sv
src/bf16Multiplier.sv
src/bf16ArithCore.sv
src/bf16ApbRegs.sv
src/bf16Coprocessor.sv
tb/bf16CoprocessorTb.sv

/* Bender.yml */
package:
  name: bf16Coprocessor

sources:
  - files:
      - src/bf16Pkg.sv
      - src/fpOperandIf.sv
      - src/bf16Divider.sv
      - src/bf16Multiplier.sv
      - src/bf16ArithCore.sv
      - src/bf16ApbRegs.sv
      - src/bf16Coprocessor.sv
  - target: test
    files:
      - tb/bf16CoprocessorTb.sv
